//--- source/fpMisc_cfg.svh
//--------------------------------------------------------------------------
// Floating-point misc unit configuration
// Lane count and single-precision field widths shared by the whole design.
//--------------------------------------------------------------------------
`ifndef FP_MISC_CFG_SVH
`define FP_MISC_CFG_SVH

// number of parallel lanes, anything from 1 to 8 works.
`define FP_LANES 4

`define FP_EXP_WIDTH  8   // biased exponent field.
`define FP_FRAC_WIDTH 23  // fraction field without the hidden bit.

// sign, exponent and fraction together.
`define FP_WIDTH (1 + `FP_EXP_WIDTH + `FP_FRAC_WIDTH)

`endif

//--- source/FpMiscPkg.sv
//--------------------------------------------------------------------------
// Floating-point misc unit types
// Operand words, internal operation codes, fclass encoding and the
// RISC-V funct5 codes of the non-rounding F-extension operations.
//--------------------------------------------------------------------------
`include "fpMisc_cfg.svh"

package FpMiscPkg;

    typedef logic [`FP_WIDTH-1:0] fpWord_t;
    typedef logic [`FP_LANES-1:0] laneMask_t;  // one bit per lane.
    typedef logic [4:0]           funct5_t;
    typedef logic [2:0]           funct3_t;

    typedef enum logic [3:0] {
        OP_SGNJ,
        OP_SGNJN,
        OP_SGNJX,
        OP_MIN,
        OP_MAX,
        OP_FEQ,
        OP_FLT,
        OP_FLE,
        OP_CLASS,
        OP_ILLEGAL
    } fpMiscOp_t;

    // one-hot class code, bit positions follow the fclass result layout.
    typedef logic [9:0] fpClass_t;

    localparam int CLS_NEG_INF       = 0;
    localparam int CLS_NEG_NORMAL    = 1;
    localparam int CLS_NEG_SUBNORMAL = 2;
    localparam int CLS_NEG_ZERO      = 3;
    localparam int CLS_POS_ZERO      = 4;
    localparam int CLS_POS_SUBNORMAL = 5;
    localparam int CLS_POS_NORMAL    = 6;
    localparam int CLS_POS_INF       = 7;
    localparam int CLS_SIGNALING_NAN = 8;
    localparam int CLS_QUIET_NAN     = 9;

    localparam fpWord_t FP_CANONICAL_NAN = 32'h7FC0_0000;

    localparam funct5_t FUNCT5_SGNJ   = 5'b00100;
    localparam funct5_t FUNCT5_MINMAX = 5'b00101;
    localparam funct5_t FUNCT5_CMP    = 5'b10100;
    localparam funct5_t FUNCT5_CLASS  = 5'b11100;

endpackage

//--- source/FpLaneIf.sv
//--------------------------------------------------------------------------
// Floating-point misc lane interface
// Carries one lane's request from the issue decoder and its response to
// the result collector. Valids are single-cycle strobes.
//--------------------------------------------------------------------------
`timescale 1ns/10ps

interface FpLaneIf import FpMiscPkg::*; ();

    logic      reqValid;
    fpMiscOp_t reqOp;
    fpWord_t   reqSrcA;
    fpWord_t   reqSrcB;

    logic      rspValid;
    fpWord_t   rspResult;
    logic      rspInvalid;  // IEEE invalid operation flag.
    logic      rspIllegal;  // set when the funct pair did not decode.

    modport issue (
        output reqValid,
        output reqOp,
        output reqSrcA,
        output reqSrcB
    );

    modport lane (
        input  reqValid,
        input  reqOp,
        input  reqSrcA,
        input  reqSrcB,
        output rspValid,
        output rspResult,
        output rspInvalid,
        output rspIllegal
    );

    modport collect (
        input  rspValid,
        input  rspResult,
        input  rspInvalid,
        input  rspIllegal
    );

endinterface

//--- source/FpClassifier.sv
//--------------------------------------------------------------------------
// Single-precision classifier
// Combinational split of one operand into sign, exponent and fraction,
// giving the one-hot ten-class code used by fclass and the NaN, zero and
// infinity rules of the lane.
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "fpMisc_cfg.svh"

module FpClassifier import FpMiscPkg::*; (
    input  fpWord_t  src,
    output fpClass_t cls
);

    logic                      sign;
    logic [`FP_EXP_WIDTH-1:0]  exponent;
    logic [`FP_FRAC_WIDTH-1:0] fraction;
    logic                      expZero;
    logic                      expOnes;
    logic                      fracZero;

    always_comb begin
        sign     = src[`FP_WIDTH-1];
        exponent = src[`FP_WIDTH-2:`FP_FRAC_WIDTH];
        fraction = src[`FP_FRAC_WIDTH-1:0];
        expZero  = (exponent == '0);
        expOnes  = (exponent == '1);
        fracZero = (fraction == '0);

        // each class bit is decoded on its own from the fields.
        cls[CLS_NEG_INF]       = sign & expOnes & fracZero;
        cls[CLS_NEG_NORMAL]    = sign & ~expZero & ~expOnes;
        cls[CLS_NEG_SUBNORMAL] = sign & expZero & ~fracZero;
        cls[CLS_NEG_ZERO]      = sign & expZero & fracZero;
        cls[CLS_POS_ZERO]      = ~sign & expZero & fracZero;
        cls[CLS_POS_SUBNORMAL] = ~sign & expZero & ~fracZero;
        cls[CLS_POS_NORMAL]    = ~sign & ~expZero & ~expOnes;
        cls[CLS_POS_INF]       = ~sign & expOnes & fracZero;

        // NaNs ignore the sign and the fraction MSB marks a quiet NaN.
        cls[CLS_SIGNALING_NAN] = expOnes & ~fracZero & ~fraction[`FP_FRAC_WIDTH-1];
        cls[CLS_QUIET_NAN]     = expOnes & ~fracZero & fraction[`FP_FRAC_WIDTH-1];

        // every known bit pattern falls into exactly one class.
        if (!$isunknown(src)) begin
            assert ($onehot(cls))
            else $error("classifier produced a non one-hot code for %h", src);
        end
    end

endmodule

//--- source/FpIssueDecoder.sv
//--------------------------------------------------------------------------
// Issue decoder
// Registers each lane's funct pair and operands and turns the RISC-V
// funct5/funct3 encoding into the internal operation code.
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "fpMisc_cfg.svh"

module FpIssueDecoder import FpMiscPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  laneMask_t inValid,
    input  funct5_t   inFunct5 [`FP_LANES],
    input  funct3_t   inFunct3 [`FP_LANES],
    input  fpWord_t   inSrcA   [`FP_LANES],
    input  fpWord_t   inSrcB   [`FP_LANES],
    FpLaneIf.issue    lanes    [`FP_LANES]
);

    function automatic fpMiscOp_t decodeOp(input funct5_t funct5, input funct3_t funct3);
        fpMiscOp_t op;
        op = OP_ILLEGAL;  // anything not listed below is illegal.
        case (funct5)
            FUNCT5_SGNJ: begin
                case (funct3)
                    3'b000:  op = OP_SGNJ;
                    3'b001:  op = OP_SGNJN;
                    3'b010:  op = OP_SGNJX;
                    default: op = OP_ILLEGAL;
                endcase
            end
            FUNCT5_MINMAX: begin
                case (funct3)
                    3'b000:  op = OP_MIN;
                    3'b001:  op = OP_MAX;
                    default: op = OP_ILLEGAL;
                endcase
            end
            FUNCT5_CMP: begin
                case (funct3)
                    3'b010:  op = OP_FEQ;
                    3'b001:  op = OP_FLT;
                    3'b000:  op = OP_FLE;
                    default: op = OP_ILLEGAL;
                endcase
            end
            FUNCT5_CLASS: begin
                op = (funct3 == 3'b001) ? OP_CLASS : OP_ILLEGAL;
            end
            default: op = OP_ILLEGAL;
        endcase
        return op;
    endfunction

    for (genvar i = 0; i < `FP_LANES; i++) begin : gLane
        always_ff @(posedge clk) begin
            if (rst) begin
                lanes[i].reqValid <= 1'b0;
            end else begin
                lanes[i].reqValid <= inValid[i];
            end
        end

        always_ff @(posedge clk) begin
            if (inValid[i]) begin  // payload only moves with a valid request.
                lanes[i].reqOp   <= decodeOp(inFunct5[i], inFunct3[i]);
                lanes[i].reqSrcA <= inSrcA[i];
                lanes[i].reqSrcB <= inSrcB[i];
            end
        end
    end

endmodule

//--- source/FpMiscLane.sv
//--------------------------------------------------------------------------
// Floating-point misc lane
// Classifies both sources and computes sign injection, min/max,
// comparisons or fclass in one register stage, with the invalid flag.
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "fpMisc_cfg.svh"

module FpMiscLane import FpMiscPkg::*; (
    input  logic   clk,
    input  logic   rst,
    FpLaneIf.lane  port
);

    fpClass_t                clsA;
    fpClass_t                clsB;
    logic                    signA;
    logic                    signB;
    logic [`FP_WIDTH-2:0]    magA;
    logic [`FP_WIDTH-2:0]    magB;
    logic                    nanA;
    logic                    nanB;
    logic                    anyNan;
    logic                    anySnan;
    logic                    bothZero;
    logic                    ltOrd;
    logic                    ltCmp;
    logic                    eqCmp;
    fpWord_t                 nextResult;
    logic                    nextInvalid;
    logic                    nextIllegal;

    FpClassifier u_classA (
        .src (port.reqSrcA),
        .cls (clsA)
    );

    FpClassifier u_classB (
        .src (port.reqSrcB),
        .cls (clsB)
    );

    always_comb begin
        signA    = port.reqSrcA[`FP_WIDTH-1];
        signB    = port.reqSrcB[`FP_WIDTH-1];
        magA     = port.reqSrcA[`FP_WIDTH-2:0];
        magB     = port.reqSrcB[`FP_WIDTH-2:0];
        nanA     = clsA[CLS_SIGNALING_NAN] | clsA[CLS_QUIET_NAN];
        nanB     = clsB[CLS_SIGNALING_NAN] | clsB[CLS_QUIET_NAN];
        anyNan   = nanA | nanB;
        anySnan  = clsA[CLS_SIGNALING_NAN] | clsB[CLS_SIGNALING_NAN];
        bothZero = (clsA[CLS_NEG_ZERO] | clsA[CLS_POS_ZERO]) &
                   (clsB[CLS_NEG_ZERO] | clsB[CLS_POS_ZERO]);

        // total order on non-NaN values where -0 sits below +0.
        if (signA != signB) begin
            ltOrd = signA;
        end else if (signA) begin
            ltOrd = magA > magB;  // larger magnitude is smaller when negative.
        end else begin
            ltOrd = magA < magB;
        end
        ltCmp = ltOrd & ~bothZero;  // IEEE compare treats the two zeros as equal.
        eqCmp = (port.reqSrcA == port.reqSrcB) | bothZero;
    end

    always_comb begin
        nextResult  = '0;
        nextInvalid = 1'b0;
        nextIllegal = 1'b0;
        case (port.reqOp)
            OP_SGNJ:  nextResult = {signB, magA};
            OP_SGNJN: nextResult = {~signB, magA};
            OP_SGNJX: nextResult = {signA ^ signB, magA};
            OP_MIN, OP_MAX: begin
                nextInvalid = anySnan;
                if (nanA && nanB) begin
                    nextResult = FP_CANONICAL_NAN;
                end else if (nanA) begin
                    nextResult = port.reqSrcB;
                end else if (nanB) begin
                    nextResult = port.reqSrcA;
                end else if (ltOrd == (port.reqOp == OP_MIN)) begin
                    nextResult = port.reqSrcA;
                end else begin
                    nextResult = port.reqSrcB;
                end
            end
            OP_FEQ: begin
                nextResult  = fpWord_t'(~anyNan & eqCmp);
                nextInvalid = anySnan;  // quiet NaNs compare equal-false silently.
            end
            OP_FLT: begin
                nextResult  = fpWord_t'(~anyNan & ltCmp);
                nextInvalid = anyNan;
            end
            OP_FLE: begin
                nextResult  = fpWord_t'(~anyNan & (ltCmp | eqCmp));
                nextInvalid = anyNan;
            end
            OP_CLASS: nextResult = fpWord_t'(clsA);
            default:  nextIllegal = 1'b1;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            port.rspValid <= 1'b0;
        end else begin
            port.rspValid <= port.reqValid;
        end
    end

    always_ff @(posedge clk) begin
        if (port.reqValid) begin
            port.rspResult  <= nextResult;
            port.rspInvalid <= nextInvalid;
            port.rspIllegal <= nextIllegal;
        end
    end

    // the decoder's reset must reach this stage before valids are trusted.
    aRspValidKnown : assert property (@(posedge clk) disable iff (rst)
        !$isunknown(port.rspValid))
    else $error("lane response valid is unknown");

endmodule

//--- source/FpResultCollector.sv
//--------------------------------------------------------------------------
// Result collector
// Registers every lane's response onto the top-level outputs and keeps
// sticky invalid and illegal flags until they are cleared.
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "fpMisc_cfg.svh"

module FpResultCollector import FpMiscPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  logic      flagClear,
    FpLaneIf.collect  lanes [`FP_LANES],
    output laneMask_t outValid,
    output fpWord_t   outResult [`FP_LANES],
    output laneMask_t outInvalid,
    output laneMask_t outIllegal,
    output logic      stickyInvalid,
    output logic      stickyIllegal
);

    laneMask_t laneValid;
    laneMask_t laneInvalid;
    laneMask_t laneIllegal;
    fpWord_t   laneResult [`FP_LANES];

    for (genvar i = 0; i < `FP_LANES; i++) begin : gGather
        assign laneValid[i]   = lanes[i].rspValid;
        assign laneResult[i]  = lanes[i].rspResult;
        assign laneInvalid[i] = lanes[i].rspInvalid;
        assign laneIllegal[i] = lanes[i].rspIllegal;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            outValid   <= '0;
            outInvalid <= '0;
            outIllegal <= '0;
            for (int i = 0; i < `FP_LANES; i++) begin
                outResult[i] <= '0;
            end
        end else begin
            outValid <= laneValid;
            for (int i = 0; i < `FP_LANES; i++) begin
                if (laneValid[i]) begin  // idle lanes hold their last result.
                    outResult[i]  <= laneResult[i];
                    outInvalid[i] <= laneInvalid[i];
                    outIllegal[i] <= laneIllegal[i];
                end
            end
        end
    end

    // a flag arriving with flagClear survives the clear.
    always_ff @(posedge clk) begin
        if (rst) begin
            stickyInvalid <= 1'b0;
            stickyIllegal <= 1'b0;
        end else begin
            stickyInvalid <= (stickyInvalid & ~flagClear) | |(laneValid & laneInvalid);
            stickyIllegal <= (stickyIllegal & ~flagClear) | |(laneValid & laneIllegal);
        end
    end

    aStickyInvalidHold : assert property (@(posedge clk) disable iff (rst)
        $fell(stickyInvalid) |-> $past(flagClear))
    else $error("sticky invalid dropped without a clear");

    aStickyIllegalHold : assert property (@(posedge clk) disable iff (rst)
        $fell(stickyIllegal) |-> $past(flagClear))
    else $error("sticky illegal dropped without a clear");

endmodule

//--- source/FpMiscUnit.sv
//--------------------------------------------------------------------------
// Floating-point misc execution unit
// Issue decoder, a row of identical lanes and the result collector.
// Three-cycle fixed latency, a new group is accepted every cycle.
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "fpMisc_cfg.svh"

module FpMiscUnit import FpMiscPkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  laneMask_t inValid,
    input  funct5_t   inFunct5 [`FP_LANES],
    input  funct3_t   inFunct3 [`FP_LANES],
    input  fpWord_t   inSrcA   [`FP_LANES],
    input  fpWord_t   inSrcB   [`FP_LANES],
    input  logic      flagClear,
    output laneMask_t outValid,
    output fpWord_t   outResult [`FP_LANES],
    output laneMask_t outInvalid,
    output laneMask_t outIllegal,
    output logic      stickyInvalid,
    output logic      stickyIllegal
);

    FpLaneIf laneIf [`FP_LANES] ();  // one request/response bundle per lane.

    FpIssueDecoder u_decoder (
        .clk      (clk),
        .rst      (rst),
        .inValid  (inValid),
        .inFunct5 (inFunct5),
        .inFunct3 (inFunct3),
        .inSrcA   (inSrcA),
        .inSrcB   (inSrcB),
        .lanes    (laneIf)
    );

    for (genvar i = 0; i < `FP_LANES; i++) begin : gLane
        FpMiscLane u_lane (
            .clk  (clk),
            .rst  (rst),
            .port (laneIf[i])
        );
    end

    FpResultCollector u_collector (
        .clk           (clk),
        .rst           (rst),
        .flagClear     (flagClear),
        .lanes         (laneIf),
        .outValid      (outValid),
        .outResult     (outResult),
        .outInvalid    (outInvalid),
        .outIllegal    (outIllegal),
        .stickyInvalid (stickyInvalid),
        .stickyIllegal (stickyIllegal)
    );

endmodule

//--- verification/FpMiscUnitTb.sv
//--------------------------------------------------------------------------
// Floating-point misc unit testbench
// Directed tests for fclass, sign injection, min/max, compares, illegal
// encodings, sticky flags and back-to-back pipelining, checked against
// a reference model built from the IEEE and RISC-V rules.
//--------------------------------------------------------------------------
`timescale 1ns/10ps
`include "fpMisc_cfg.svh"

module FpMiscUnitTb import FpMiscPkg::*; ();

    localparam int MAX_CYCLES = 2000;  // the tests need roughly 200 cycles.
    localparam int PIPE_GROUPS = 6;

    logic      clk;
    logic      rst;
    laneMask_t inValid;
    funct5_t   inFunct5 [`FP_LANES];
    funct3_t   inFunct3 [`FP_LANES];
    fpWord_t   inSrcA   [`FP_LANES];
    fpWord_t   inSrcB   [`FP_LANES];
    logic      flagClear;
    laneMask_t outValid;
    fpWord_t   outResult [`FP_LANES];
    laneMask_t outInvalid;
    laneMask_t outIllegal;
    logic      stickyInvalid;
    logic      stickyIllegal;

    funct5_t   curF5 [`FP_LANES];  // next group to be issued.
    funct3_t   curF3 [`FP_LANES];
    fpWord_t   curA  [`FP_LANES];
    fpWord_t   curB  [`FP_LANES];
    funct5_t   pF5   [PIPE_GROUPS][`FP_LANES];
    funct3_t   pF3   [PIPE_GROUPS][`FP_LANES];
    fpWord_t   pA    [PIPE_GROUPS][`FP_LANES];
    fpWord_t   pB    [PIPE_GROUPS][`FP_LANES];
    laneMask_t pMask [PIPE_GROUPS];
    logic      expStickyInv;
    logic      expStickyIll;
    int        seed;
    int        cycles;

    FpMiscUnit u_dut (
        .clk           (clk),
        .rst           (rst),
        .inValid       (inValid),
        .inFunct5      (inFunct5),
        .inFunct3      (inFunct3),
        .inSrcA        (inSrcA),
        .inSrcB        (inSrcB),
        .flagClear     (flagClear),
        .outValid      (outValid),
        .outResult     (outResult),
        .outInvalid    (outInvalid),
        .outIllegal    (outIllegal),
        .stickyInvalid (stickyInvalid),
        .stickyIllegal (stickyIllegal)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the tests did not finish within %0d cycles", MAX_CYCLES);
            $display("Simulation failed");
            $fatal(1);
        end
    end

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        if (expected !== actual) begin
            $display("error %s expected %h actual %h", name, expected, actual);
            $display("Simulation failed");
            $fatal(1);
        end
    endtask

    function automatic logic isNan(input fpWord_t w);
        return (w[30:23] == 8'hFF) && (w[22:0] != 0);
    endfunction

    function automatic logic isZero(input fpWord_t w);
        return w[30:0] == 0;
    endfunction

    // maps a float onto an unsigned key that sorts in numeric order, -0 below +0.
    function automatic logic [31:0] orderKey(input fpWord_t w);
        return w[31] ? ~w : (w | 32'h8000_0000);
    endfunction

    function automatic fpWord_t refClass(input fpWord_t w);
        int idx;
        if (w[30:23] == 8'hFF) begin
            idx = (w[22:0] == 0) ? (w[31] ? 0 : 7) : (w[22] ? 9 : 8);
        end else if (w[30:23] == 0) begin
            idx = (w[22:0] == 0) ? (w[31] ? 3 : 4) : (w[31] ? 2 : 5);
        end else begin
            idx = w[31] ? 1 : 6;
        end
        return 32'd1 << idx;
    endfunction

    task automatic refModel(input funct5_t f5, input funct3_t f3, input fpWord_t a,
                            input fpWord_t b, output fpWord_t r, output logic inv,
                            output logic ill);
        logic snan;
        logic nan;
        logic eq;
        logic lt;
        snan = (isNan(a) && !a[22]) || (isNan(b) && !b[22]);
        nan  = isNan(a) || isNan(b);
        eq   = (a == b) || (isZero(a) && isZero(b));
        lt   = (orderKey(a) < orderKey(b)) && !(isZero(a) && isZero(b));
        r    = '0;
        inv  = 1'b0;
        ill  = 1'b0;
        if (f5 == FUNCT5_SGNJ && f3 <= 2) begin
            r = {(f3 == 0) ? b[31] : (f3 == 1) ? !b[31] : a[31] ^ b[31], a[30:0]};
        end else if (f5 == FUNCT5_MINMAX && f3 <= 1) begin
            inv = snan;
            if (isNan(a) && isNan(b)) r = FP_CANONICAL_NAN;
            else if (isNan(a)) r = b;
            else if (isNan(b)) r = a;
            else r = ((f3 == 0) == (orderKey(a) < orderKey(b))) ? a : b;
        end else if (f5 == FUNCT5_CMP && f3 <= 2) begin
            inv = (f3 == 2) ? snan : nan;  // feq is quiet on quiet NaNs.
            r   = (f3 == 2) ? eq : (f3 == 1) ? lt : (lt | eq);
            if (nan) r = '0;
        end else if (f5 == FUNCT5_CLASS && f3 == 1) begin
            r = refClass(a);
        end else begin
            ill = 1'b1;
        end
    endtask

    task automatic checkLanes(input string name, input laneMask_t mask,
                              input funct5_t f5 [`FP_LANES], input funct3_t f3 [`FP_LANES],
                              input fpWord_t a [`FP_LANES], input fpWord_t b [`FP_LANES]);
        fpWord_t r;
        logic    inv;
        logic    ill;
        checkValue({name, " valid"}, mask, outValid);
        for (int i = 0; i < `FP_LANES; i++) begin
            if (mask[i]) begin
                refModel(f5[i], f3[i], a[i], b[i], r, inv, ill);
                checkValue($sformatf("%s lane %0d result", name, i), r, outResult[i]);
                checkValue($sformatf("%s lane %0d invalid", name, i), inv, outInvalid[i]);
                checkValue($sformatf("%s lane %0d illegal", name, i), ill, outIllegal[i]);
                expStickyInv = expStickyInv | inv;
                expStickyIll = expStickyIll | ill;
            end
        end
        checkValue({name, " sticky invalid"}, expStickyInv, stickyInvalid);
        checkValue({name, " sticky illegal"}, expStickyIll, stickyIllegal);
    endtask

    task automatic driveGroup(input laneMask_t mask);
        for (int i = 0; i < `FP_LANES; i++) begin
            inFunct5[i] = curF5[i];
            inFunct3[i] = curF3[i];
            inSrcA[i]   = curA[i];
            inSrcB[i]   = curB[i];
        end
        inValid = mask;
    endtask

    // issues one group and checks it on the third edge after it is driven.
    task automatic runGroup(input string name, input laneMask_t mask);
        driveGroup(mask);
        @(posedge clk);
        #1 inValid = '0;
        repeat (2) @(posedge clk);
        #1;
        checkLanes(name, mask, curF5, curF3, curA, curB);
    endtask

    function automatic fpWord_t randomOperand();
        fpWord_t w;
        w = $random(seed);
        case ($unsigned($random(seed)) % 8)
            0: w = 32'h7FC0_0000 | (w & 32'h8000_FFFF);  // quiet NaN.
            1: w = 32'h7F80_0001 | (w & 32'h8000_FFFF);  // signaling NaN.
            default: ;
        endcase
        return w;
    endfunction

    // normal numbers with a moderate exponent, never NaN, infinity or subnormal.
    function automatic fpWord_t randomNormal();
        fpWord_t w;
        w = $random(seed);
        return (w & 32'hBEFF_FFFF) | 32'h0080_0000;
    endfunction

    task automatic testClass();
        fpWord_t reps [10];
        int      k;
        reps = '{32'hFF80_0000, 32'hBF80_0000, 32'h8000_0001, 32'h8000_0000,
                 32'h0000_0000, 32'h0000_0001, 32'h3F80_0000, 32'h7F80_0000,
                 32'h7F80_0001, 32'h7FC0_0000};
        k = 0;
        while (k < 10) begin
            for (int i = 0; i < `FP_LANES; i++) begin
                curF5[i] = FUNCT5_CLASS;
                curF3[i] = 3'b001;
                curA[i]  = reps[(k + i) % 10];
                curB[i]  = '0;
            end
            runGroup("class", '1);
            k += `FP_LANES;
        end
    endtask

    task automatic testSignInject();
        for (int g = 0; g < 8; g++) begin
            for (int i = 0; i < `FP_LANES; i++) begin
                curF5[i] = FUNCT5_SGNJ;
                curF3[i] = (g + i) % 3;
                curA[i]  = randomOperand();
                curB[i]  = randomOperand();
            end
            runGroup("sign injection", '1);
        end
    endtask

    task automatic testMinMax();
        fpWord_t dirA [8];
        fpWord_t dirB [8];
        dirA = '{32'h8000_0000, 32'h0000_0000, 32'h7FC0_0000, 32'h4000_0000,
                 32'h7FC0_0000, 32'h7F80_0001, 32'hC040_0000, 32'h7F80_0002};
        dirB = '{32'h0000_0000, 32'h8000_0000, 32'h3F80_0000, 32'h7F80_0001,
                 32'h7F80_0001, 32'h7FC0_0000, 32'hC000_0000, 32'h7F80_0003};
        for (int g = 0; g < 16; g++) begin
            for (int i = 0; i < `FP_LANES; i++) begin
                curF5[i] = FUNCT5_MINMAX;
                curF3[i] = (g + i) % 2;
                curA[i]  = (g < 8) ? dirA[(g + i) % 8] : randomNormal();
                curB[i]  = (g < 8) ? dirB[(g + i) % 8] : randomNormal();
            end
            runGroup("min max", '1);
        end
    endtask

    task automatic testCompare();
        fpWord_t vals [6];
        vals = '{32'h7FC0_0000, 32'h7F80_0001, 32'h3F80_0000,
                 32'h8000_0000, 32'h0000_0000, 32'hBF80_0000};
        for (int g = 0; g < 36; g++) begin
            for (int i = 0; i < `FP_LANES; i++) begin
                curF5[i] = FUNCT5_CMP;
                curF3[i] = i % 3;
                curA[i]  = vals[g % 6];
                curB[i]  = vals[(g / 6 + i) % 6];
            end
            runGroup("compare", '1);
        end
    endtask

    task automatic testIllegalSticky();
        for (int i = 0; i < `FP_LANES; i++) begin
            curF5[i] = (i % 2) ? FUNCT5_CLASS : 5'b11111;
            curF3[i] = (i % 2) ? 3'b000 : 3'b001;
            curA[i]  = $random(seed);
            curB[i]  = $random(seed);
        end
        runGroup("illegal", '1);
        @(posedge clk);
        #1 flagClear = 1'b1;
        @(posedge clk);
        #1 flagClear = 1'b0;
        expStickyInv = 1'b0;
        expStickyIll = 1'b0;
        checkValue("sticky clear invalid", 1'b0, stickyInvalid);
        checkValue("sticky clear illegal", 1'b0, stickyIllegal);
    endtask

    task automatic testPipeline();
        funct5_t codes [4];
        codes = '{FUNCT5_SGNJ, FUNCT5_MINMAX, FUNCT5_CMP, FUNCT5_CLASS};
        for (int g = 0; g < PIPE_GROUPS; g++) begin
            pMask[g] = $random(seed);
            for (int i = 0; i < `FP_LANES; i++) begin
                pF5[g][i] = codes[$unsigned($random(seed)) % 4];
                pF3[g][i] = $unsigned($random(seed)) % 4;
                pA[g][i]  = randomOperand();
                pB[g][i]  = randomOperand();
            end
        end
        curF5 = pF5[0];
        curF3 = pF3[0];
        curA  = pA[0];
        curB  = pB[0];
        driveGroup(pMask[0]);
        for (int c = 0; c < PIPE_GROUPS + 2; c++) begin
            @(posedge clk);
            #1;
            if (c >= 2) begin  // group c-2 leaves on the third edge after it is driven.
                checkLanes("pipeline", pMask[c - 2], pF5[c - 2], pF3[c - 2],
                           pA[c - 2], pB[c - 2]);
            end
            if (c + 1 < PIPE_GROUPS) begin
                curF5 = pF5[c + 1];
                curF3 = pF3[c + 1];
                curA  = pA[c + 1];
                curB  = pB[c + 1];
                driveGroup(pMask[c + 1]);
            end else begin
                inValid = '0;
            end
        end
    endtask

    initial begin
        seed         = 25239;
        cycles       = 0;
        clk          = 1'b0;
        rst          = 1'b1;
        flagClear    = 1'b0;
        inValid      = '0;
        expStickyInv = 1'b0;
        expStickyIll = 1'b0;
        for (int i = 0; i < `FP_LANES; i++) begin
            inFunct5[i] = '0;
            inFunct3[i] = '0;
            inSrcA[i]   = '0;
            inSrcB[i]   = '0;
        end
        repeat (2) @(posedge clk);
        #1 rst = 1'b0;
        testClass();
        testSignInject();
        testMinMax();
        testCompare();
        testIllegalSticky();
        testPipeline();
        $display("Simulation completed successfully");
        $finish;
    end

endmodule

//--- verilog.f
+incdir+source
source/FpMiscPkg.sv
source/FpLaneIf.sv
source/FpClassifier.sv
source/FpIssueDecoder.sv
source/FpMiscLane.sv
source/FpResultCollector.sv
source/FpMiscUnit.sv
verification/FpMiscUnitTb.sv

//--- Makefile
# Verilator build for the floating-point misc unit.

VERILATOR ?= verilator
TOP       ?= FpMiscUnitTb
RTL_TOP   ?= FpMiscUnit
FILELIST  ?= verilog.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST)
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; \
	cat $(LOG); \
	if grep -q "Simulation failed" $(LOG) || [ $$status -ne 0 ]; then \
		echo "FAIL"; exit 1; \
	else \
		echo "PASS"; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
